// File: src.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/ooo_core_pkg.sv
hw/apb_issue_port.sv
hw/rename_unit.sv
hw/phys_reg_file.sv
hw/alu_station.sv
hw/retire_unit.sv
hw/ooo_core_top.sv
tests/ooo_core_properties.sv
tests/ooo_core_tb.sv

// File: Bender.yml
package:
  name: ooo_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_isa_pkg.sv
      - hw/ooo_core_pkg.sv
      - hw/apb_issue_port.sv
      - hw/rename_unit.sv
      - hw/phys_reg_file.sv
      - hw/alu_station.sv
      - hw/retire_unit.sv
      - hw/ooo_core_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/ooo_core_properties.sv
      - tests/ooo_core_tb.sv

// File: tests/ooo_core_tb.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module ooo_core_tb;

    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam int stall_limit = 200; // cycles per APB transfer
    localparam int idle_limit = 2000; // status polls

    logic clk = 1'b0;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [11:0] paddr;
    logic [`OOO_XLEN-1:0] pwdata;
    logic [`OOO_XLEN-1:0] prdata;
    logic pready;
    logic pslverr;

    logic [31:0] model [32]; // architectural state as RV32I defines it
    logic [31:0] rng;
    string test_name;

    ooo_core_top u_ooo_core_top (.*);

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // bound checker failures end the run at once
    always @(u_ooo_core_top.u_ooo_core_properties.fail_count) begin
        if (u_ooo_core_top.u_ooo_core_properties.fail_count != 0) begin
            $display("a bound APB assertion failed");
            abort_run();
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc_op_imm};
    endfunction

    function automatic logic [31:0] u_type_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, opc_lui};
    endfunction

    // high bits of the lcg words pick the fields
    function automatic logic [31:0] random_instr(input logic [31:0] r1, input logic [31:0] r2);
        logic [2:0] f3;
        logic [6:0] hi;
        logic [11:0] imm;
        f3 = r1[12:10];
        hi = (r2[19] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0;
        case (r1[31:28] % 4'd3)
            4'd0: return r_type_word(hi, r1[17:13], r1[22:18], f3, r1[27:23]);
            4'd1: begin
                imm = r2[31:20];
                if (f3 == 3'd1 || f3 == 3'd5) imm = {(f3 == 3'd5) ? hi : 7'b0, r2[24:20]}; // shamt
                return i_type_word(imm, r1[22:18], f3, r1[27:23]);
            end
            default: return u_type_word(r2[31:12], r1[27:23]);
        endcase
    endfunction

    task automatic model_apply(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a = model[w[19:15]];
        b = (w[6:0] == opc_op) ? model[w[24:20]] : {{20{w[31]}}, w[31:20]};
        case (w[14:12])
            3'd0: res = (w[6:0] == opc_op && w[30]) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (w[30]) res = $signed(a) >>> b[4:0];
                else res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        if (w[6:0] == opc_lui) res = {w[31:12], 12'b0};
        if (w[11:7] != 5'd0) model[w[11:7]] = res;
    endtask

    // called at a falling edge, returns at the falling edge after completion
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        waited = 0;
        @(posedge clk); // pready seen at the edge that ends the access
        while (!pready && waited < stall_limit) begin
            @(posedge clk);
            waited++;
        end
        if (!pready) begin
            $display("APB transfer to address %h did not complete in %0d cycles", addr, waited);
            abort_run();
        end
        rdata = prdata;
        err = pslverr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic push_instr(input logic [31:0] word, input logic expect_err);
        logic [31:0] unused;
        logic err;
        apb_transfer(1'b1, `OOO_ADDR_INSTR, word, unused, err);
        assert (err === expect_err) else begin
            $display("FAILED %s pslverr for %h: expected %b, actual %b",
                     test_name, word, expect_err, err);
            abort_run();
        end
        if (!err) model_apply(word);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        logic err;
        int polls;
        polls = 0;
        apb_transfer(1'b0, `OOO_ADDR_STATUS, '0, status, err);
        while (!status[0] && polls < idle_limit) begin
            apb_transfer(1'b0, `OOO_ADDR_STATUS, '0, status, err);
            polls++;
        end
        if (!status[0]) begin
            $display("core still busy after %0d status reads in %s", polls, test_name);
            abort_run();
        end
    endtask

    task automatic compare_regs();
        logic [31:0] value;
        logic err;
        for (int i = 0; i < 32; i++) begin
            apb_transfer(1'b0, 12'(`OOO_ADDR_REGS + 4 * i), '0, value, err);
            assert (value === model[i]) else begin
                $display("FAILED %s x%0d: expected %h, actual %h", test_name, i, model[i], value);
                abort_run();
            end
        end
    endtask

    initial begin
        logic [31:0] status;
        logic [31:0] r1;
        logic err;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        for (int i = 0; i < 32; i++) model[i] = '0;
        rng = 32'haa8f;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        test_name = "reset_state";
        apb_transfer(1'b0, `OOO_ADDR_STATUS, '0, status, err);
        assert (status[0] === 1'b1) else begin
            $display("FAILED %s idle bit: expected 1, actual %b", test_name, status[0]);
            abort_run();
        end
        compare_regs();

        test_name = "dependent_pair";
        push_instr(i_type_word(12'hff9, 5'd0, 3'd0, 5'd1), 1'b0); // addi x1, x0, -7
        push_instr(r_type_word(7'd0, 5'd1, 5'd1, 3'd0, 5'd2), 1'b0); // add x2, x1, x1
        wait_idle();
        compare_regs();

        test_name = "random_stream";
        for (int n = 0; n < 200; n++) begin
            rng = lcg_next(rng);
            r1 = rng;
            rng = lcg_next(rng);
            push_instr(random_instr(r1, rng), 1'b0);
        end
        wait_idle();
        compare_regs();

        test_name = "x0_handling";
        push_instr(u_type_word(20'h12345, 5'd5), 1'b0);
        push_instr(i_type_word(12'h07b, 5'd5, 3'd0, 5'd0), 1'b0); // addi x0, x5, 123
        push_instr(u_type_word(20'hdead0, 5'd0), 1'b0);
        push_instr(r_type_word(7'd0, 5'd0, 5'd5, 3'd6, 5'd6), 1'b0); // or x6, x5, x0
        push_instr(r_type_word(7'h20, 5'd5, 5'd0, 3'd0, 5'd7), 1'b0); // sub x7, x0, x5
        wait_idle();
        compare_regs();

        test_name = "illegal_opcode";
        push_instr(32'h00002083, 1'b1); // lw x1, 0(x0)
        wait_idle();
        compare_regs();

        if (u_ooo_core_top.u_ooo_core_properties.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("bound APB assertions failed %0d times",
                     u_ooo_core_top.u_ooo_core_properties.fail_count);
            abort_run();
        end
    end

endmodule

// File: tests/ooo_core_properties.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module ooo_core_properties (
    input logic clk,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [11:0] paddr,
    input logic [`OOO_XLEN-1:0] pwdata,
    input logic pready,
    input logic pslverr
);

    int unsigned fail_count;

    initial fail_count = 0;

    err_needs_ready: assert property (@(posedge clk) disable iff (reset) pslverr |-> pready)
        else begin
            fail_count++;
            $error("pslverr raised without pready");
        end

    ready_needs_access: assert property (@(posedge clk) disable iff (reset)
        pready |-> psel && penable)
        else begin
            fail_count++;
            $error("pready raised outside an access phase");
        end

    // a stalled push keeps its address and data
    stall_keeps_bus: assert property (@(posedge clk) disable iff (reset)
        psel && penable && !pready |=> psel && $stable(paddr) && $stable(pwdata)
            && $stable(pwrite))
        else begin
            fail_count++;
            $error("APB request changed during a stalled transfer");
        end

endmodule

bind ooo_core_top ooo_core_properties u_ooo_core_properties (.*);

// File: hw/ooo_core_top.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module ooo_core_top (
    input  logic clk,
    input  logic reset,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [11:0] paddr,
    input  logic [`OOO_XLEN-1:0] pwdata,
    output logic [`OOO_XLEN-1:0] prdata,
    output logic pready,
    output logic pslverr
);

    logic [`OOO_XLEN-1:0] instr;
    logic instr_valid;
    logic dispatch_ready;
    logic illegal;
    logic dispatch;
    rv_isa_pkg::alu_op_e alu_op;
    ooo_core_pkg::phys_tag_t src1_tag;
    ooo_core_pkg::phys_tag_t src2_tag;
    ooo_core_pkg::phys_tag_t dst_tag;
    ooo_core_pkg::phys_tag_t old_tag;
    ooo_core_pkg::phys_tag_t free_tag;
    ooo_core_pkg::phys_tag_t wb_tag;
    ooo_core_pkg::arch_reg_t dst_arch;
    ooo_core_pkg::arch_reg_t arch_raddr;
    ooo_core_pkg::rob_idx_t rob_idx;
    ooo_core_pkg::rob_idx_t wb_rob_idx;
    logic use_imm;
    logic has_dst;
    logic [`OOO_XLEN-1:0] imm;
    logic [`OOO_XLEN-1:0] src1_data;
    logic [`OOO_XLEN-1:0] src2_data;
    logic [`OOO_XLEN-1:0] wb_data;
    logic [`OOO_XLEN-1:0] arch_rdata;
    logic src1_ready;
    logic src2_ready;
    logic rob_full;
    logic rob_empty;
    logic rs_full;
    logic free_valid;
    logic wb_valid;

    apb_issue_port u_apb_issue_port (.*);

    rename_unit u_rename_unit (.*);

    phys_reg_file u_phys_reg_file (.alloc(dispatch), .alloc_tag(dst_tag), .*);

    alu_station u_alu_station (.alloc(dispatch), .*);

    retire_unit u_retire_unit (.alloc(dispatch), .*);

endmodule

// File: hw/retire_unit.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module retire_unit (
    input  logic clk,
    input  logic reset,
    input  logic alloc,
    input  logic has_dst,
    input  ooo_core_pkg::arch_reg_t dst_arch,
    input  ooo_core_pkg::phys_tag_t dst_tag,
    input  ooo_core_pkg::phys_tag_t old_tag,
    output ooo_core_pkg::rob_idx_t rob_idx,
    output logic rob_full,
    output logic rob_empty,
    input  logic wb_valid,
    input  ooo_core_pkg::rob_idx_t wb_rob_idx,
    input  logic [`OOO_XLEN-1:0] wb_data,
    output logic free_valid,
    output ooo_core_pkg::phys_tag_t free_tag,
    input  ooo_core_pkg::arch_reg_t arch_raddr,
    output logic [`OOO_XLEN-1:0] arch_rdata
);

    logic [`OOO_ROB_DEPTH-1:0] done;
    logic [`OOO_ROB_DEPTH-1:0] writes;
    ooo_core_pkg::arch_reg_t arch_q [`OOO_ROB_DEPTH];
    ooo_core_pkg::phys_tag_t old_q [`OOO_ROB_DEPTH];
    logic [`OOO_XLEN-1:0] value_q [`OOO_ROB_DEPTH];
    logic [`OOO_XLEN-1:0] arch_regs [`OOO_ARCH_REGS];
    ooo_core_pkg::rob_idx_t head;
    ooo_core_pkg::rob_idx_t tail;
    logic [3:0] count;
    logic commit;

    assign rob_idx = tail;
    assign rob_full = (count == 4'(`OOO_ROB_DEPTH));
    assign rob_empty = (count == '0);
    assign commit = !rob_empty && done[head]; // strictly in order
    assign free_valid = commit && writes[head] && (old_q[head] != '0);
    assign free_tag = old_q[head];
    assign arch_rdata = arch_regs[arch_raddr];

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            done <= '0;
            for (int r = 0; r < `OOO_ARCH_REGS; r++) begin
                arch_regs[r] <= '0;
            end
        end else begin
            if (alloc) begin
                done[tail] <= 1'b0;
                tail <= tail + 3'd1;
            end
            if (wb_valid) done[wb_rob_idx] <= 1'b1;
            if (commit) begin
                head <= head + 3'd1;
                if (writes[head]) arch_regs[arch_q[head]] <= value_q[head];
            end
            count <= count + 4'(alloc) - 4'(commit);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            writes[tail] <= has_dst && (dst_tag != '0); // x0 carries tag 0
            arch_q[tail] <= dst_arch;
            old_q[tail] <= old_tag;
        end
        if (wb_valid) value_q[wb_rob_idx] <= wb_data;
    end

endmodule

// File: hw/alu_station.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module alu_station (
    input  logic clk,
    input  logic reset,
    input  logic alloc,
    input  rv_isa_pkg::alu_op_e alu_op,
    input  ooo_core_pkg::phys_tag_t src1_tag,
    input  ooo_core_pkg::phys_tag_t src2_tag,
    input  logic [`OOO_XLEN-1:0] src1_data,
    input  logic src1_ready,
    input  logic [`OOO_XLEN-1:0] src2_data,
    input  logic src2_ready,
    input  logic use_imm,
    input  logic [`OOO_XLEN-1:0] imm,
    input  ooo_core_pkg::phys_tag_t dst_tag,
    input  ooo_core_pkg::rob_idx_t rob_idx,
    output logic rs_full,
    output logic wb_valid,
    output ooo_core_pkg::phys_tag_t wb_tag,
    output ooo_core_pkg::rob_idx_t wb_rob_idx,
    output logic [`OOO_XLEN-1:0] wb_data
);

    logic [`OOO_RS_DEPTH-1:0] valid;
    logic [`OOO_RS_DEPTH-1:0] rdy1;
    logic [`OOO_RS_DEPTH-1:0] rdy2;
    logic [`OOO_RS_DEPTH-1:0] use_imm_q;
    logic [1:0] age [`OOO_RS_DEPTH]; // younger entries still waiting
    rv_isa_pkg::alu_op_e op_q [`OOO_RS_DEPTH];
    ooo_core_pkg::phys_tag_t tag1 [`OOO_RS_DEPTH];
    ooo_core_pkg::phys_tag_t tag2 [`OOO_RS_DEPTH];
    ooo_core_pkg::phys_tag_t dst_q [`OOO_RS_DEPTH];
    ooo_core_pkg::rob_idx_t rob_q [`OOO_RS_DEPTH];
    logic [`OOO_XLEN-1:0] val1 [`OOO_RS_DEPTH];
    logic [`OOO_XLEN-1:0] val2 [`OOO_RS_DEPTH];
    logic [`OOO_XLEN-1:0] imm_q [`OOO_RS_DEPTH];
    logic issue;
    logic [1:0] sel;
    logic [1:0] slot;
    logic [`OOO_XLEN-1:0] a;
    logic [`OOO_XLEN-1:0] b;
    logic [`OOO_XLEN-1:0] result;

    assign rs_full = &valid;

    // oldest ready entry wins
    always_comb begin
        issue = 1'b0;
        sel = '0;
        slot = '0;
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            if (valid[i] && rdy1[i] && rdy2[i] && (!issue || age[i] > age[sel])) begin
                issue = 1'b1;
                sel = 2'(i);
            end
            if (!valid[i]) slot = 2'(i);
        end
    end

    assign a = val1[sel];
    assign b = use_imm_q[sel] ? imm_q[sel] : val2[sel];

    always_comb begin
        case (op_q[sel])
            rv_isa_pkg::alu_sub: result = a - b;
            rv_isa_pkg::alu_and: result = a & b;
            rv_isa_pkg::alu_or: result = a | b;
            rv_isa_pkg::alu_xor: result = a ^ b;
            rv_isa_pkg::alu_sll: result = a << b[4:0];
            rv_isa_pkg::alu_srl: result = a >> b[4:0];
            rv_isa_pkg::alu_sra: result = $signed(a) >>> b[4:0];
            rv_isa_pkg::alu_slt: result = {{(`OOO_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rv_isa_pkg::alu_sltu: result = {{(`OOO_XLEN-1){1'b0}}, a < b};
            rv_isa_pkg::alu_pass_b: result = b;
            default: result = a + b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= issue;
            if (issue) valid[sel] <= 1'b0;
            if (alloc) valid[slot] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            if (wb_valid && !rdy1[i] && tag1[i] == wb_tag) begin
                rdy1[i] <= 1'b1;
                val1[i] <= wb_data;
            end
            if (wb_valid && !rdy2[i] && tag2[i] == wb_tag) begin
                rdy2[i] <= 1'b1;
                val2[i] <= wb_data;
            end
            age[i] <= age[i] + 2'(alloc) - 2'(issue && age[i] > age[sel]);
        end
        if (alloc) begin
            op_q[slot] <= alu_op;
            tag1[slot] <= src1_tag;
            tag2[slot] <= src2_tag;
            // catch a result broadcast in the insert cycle
            rdy1[slot] <= src1_ready || (wb_valid && wb_tag == src1_tag);
            rdy2[slot] <= src2_ready || (wb_valid && wb_tag == src2_tag);
            val1[slot] <= src1_ready ? src1_data : wb_data;
            val2[slot] <= src2_ready ? src2_data : wb_data;
            use_imm_q[slot] <= use_imm;
            imm_q[slot] <= imm;
            dst_q[slot] <= dst_tag;
            rob_q[slot] <= rob_idx;
            age[slot] <= '0;
        end
        wb_tag <= dst_q[sel];
        wb_rob_idx <= rob_q[sel];
        wb_data <= result;
    end

endmodule

// File: hw/phys_reg_file.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module phys_reg_file (
    input  logic clk,
    input  logic reset,
    input  ooo_core_pkg::phys_tag_t src1_tag,
    input  ooo_core_pkg::phys_tag_t src2_tag,
    input  logic alloc,
    input  ooo_core_pkg::phys_tag_t alloc_tag,
    output logic [`OOO_XLEN-1:0] src1_data,
    output logic src1_ready,
    output logic [`OOO_XLEN-1:0] src2_data,
    output logic src2_ready,
    input  logic wb_valid,
    input  ooo_core_pkg::phys_tag_t wb_tag,
    input  logic [`OOO_XLEN-1:0] wb_data
);

    logic [`OOO_XLEN-1:0] regs [`OOO_PHYS_REGS];
    logic [`OOO_PHYS_REGS-1:0] ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= '1;
        end else begin
            if (wb_valid) ready[wb_tag] <= 1'b1;
            if (alloc && alloc_tag != '0) ready[alloc_tag] <= 1'b0; // pending producer
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid) regs[wb_tag] <= wb_data;
    end

    // tag 0 stands for x0
    assign src1_data = (src1_tag == '0) ? '0 : regs[src1_tag];
    assign src2_data = (src2_tag == '0) ? '0 : regs[src2_tag];
    assign src1_ready = (src1_tag == '0) || ready[src1_tag];
    assign src2_ready = (src2_tag == '0) || ready[src2_tag];

endmodule

// File: hw/rename_unit.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module rename_unit (
    input  logic clk,
    input  logic reset,
    input  logic [`OOO_XLEN-1:0] instr,
    input  logic instr_valid,
    output logic dispatch_ready,
    output logic illegal,
    output logic dispatch,
    output rv_isa_pkg::alu_op_e alu_op,
    output ooo_core_pkg::phys_tag_t src1_tag,
    output ooo_core_pkg::phys_tag_t src2_tag,
    output logic use_imm,
    output logic [`OOO_XLEN-1:0] imm,
    output ooo_core_pkg::phys_tag_t dst_tag,
    output ooo_core_pkg::arch_reg_t dst_arch,
    output ooo_core_pkg::phys_tag_t old_tag,
    output logic has_dst,
    input  logic rob_full,
    input  logic rs_full,
    input  logic free_valid,
    input  ooo_core_pkg::phys_tag_t free_tag
);

    rv_isa_pkg::opcode_e opcode;
    logic is_op;
    logic is_op_imm;
    logic is_lui;
    logic pop;
    ooo_core_pkg::phys_tag_t rat [`OOO_ARCH_REGS];
    ooo_core_pkg::phys_tag_t free_q [`OOO_PHYS_REGS];
    logic [5:0] fq_head;
    logic [5:0] fq_tail;
    logic [5:0] fq_count;

    function automatic logic [5:0] next_ptr(input logic [5:0] p);
        return (p == 6'(`OOO_PHYS_REGS - 1)) ? 6'd0 : p + 6'd1;
    endfunction

    assign opcode = rv_isa_pkg::opcode_e'(instr[6:0]);
    assign is_op = (opcode == rv_isa_pkg::op);
    assign is_op_imm = (opcode == rv_isa_pkg::op_imm);
    assign is_lui = (opcode == rv_isa_pkg::lui);
    assign illegal = !(is_op || is_op_imm || is_lui);

    assign dst_arch = instr[11:7];
    assign has_dst = (dst_arch != '0); // x0 gets no tag
    assign use_imm = !is_op;
    assign imm = is_lui ? {instr[31:12], 12'b0} : {{20{instr[31]}}, instr[31:20]};

    always_comb begin
        case (instr[14:12])
            3'd0: alu_op = (is_op && instr[30]) ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
            3'd1: alu_op = rv_isa_pkg::alu_sll;
            3'd2: alu_op = rv_isa_pkg::alu_slt;
            3'd3: alu_op = rv_isa_pkg::alu_sltu;
            3'd4: alu_op = rv_isa_pkg::alu_xor;
            3'd5: alu_op = instr[30] ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl; // srai too
            3'd6: alu_op = rv_isa_pkg::alu_or;
            default: alu_op = rv_isa_pkg::alu_and;
        endcase
        if (is_lui) begin
            alu_op = rv_isa_pkg::alu_pass_b;
        end
    end

    assign src1_tag = is_lui ? '0 : rat[instr[19:15]];
    assign src2_tag = is_op ? rat[instr[24:20]] : '0;
    assign old_tag = rat[dst_arch];
    assign dst_tag = has_dst ? free_q[fq_head] : '0;

    assign dispatch_ready = !rob_full && !rs_full && (!has_dst || fq_count != '0);
    assign dispatch = instr_valid && !illegal && dispatch_ready;
    assign pop = dispatch && has_dst;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
                free_q[i] <= 6'(i + 1); // tags 1 to 47, last slot spare
            end
            for (int r = 0; r < `OOO_ARCH_REGS; r++) begin
                rat[r] <= '0;
            end
            fq_head <= '0;
            fq_tail <= 6'(`OOO_PHYS_REGS - 1);
            fq_count <= 6'(`OOO_PHYS_REGS - 1);
        end else begin
            if (pop) begin
                rat[dst_arch] <= dst_tag;
                fq_head <= next_ptr(fq_head);
            end
            if (free_valid) begin
                free_q[fq_tail] <= free_tag; // refill at commit
                fq_tail <= next_ptr(fq_tail);
            end
            fq_count <= fq_count + 6'(free_valid) - 6'(pop);
        end
    end

endmodule

// File: hw/apb_issue_port.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module apb_issue_port (
    input  logic clk,
    input  logic reset,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [11:0] paddr,
    input  logic [`OOO_XLEN-1:0] pwdata,
    output logic [`OOO_XLEN-1:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic [`OOO_XLEN-1:0] instr,
    output logic instr_valid,
    input  logic dispatch_ready,
    input  logic illegal,
    input  logic rob_empty,
    output ooo_core_pkg::arch_reg_t arch_raddr,
    input  logic [`OOO_XLEN-1:0] arch_rdata
);

    ooo_core_pkg::apb_state_e state;
    logic access_phase;
    logic instr_wr;
    logic reg_hit;

    // penable only counts after a setup cycle
    assign access_phase = psel && penable && (state != ooo_core_pkg::idle);
    assign instr_wr = pwrite && (paddr == `OOO_ADDR_INSTR);
    assign reg_hit = (paddr >= `OOO_ADDR_REGS) && (paddr < `OOO_ADDR_REGS + 4 * `OOO_ARCH_REGS);

    assign instr = pwdata;
    assign instr_valid = access_phase && instr_wr;
    assign pready = access_phase && (!instr_wr || illegal || dispatch_ready); // stall on push
    assign pslverr = access_phase && instr_wr && illegal;
    assign arch_raddr = paddr[6:2];

    always_comb begin
        prdata = '0;
        if (paddr == `OOO_ADDR_STATUS) begin
            prdata[0] = rob_empty; // idle bit
        end else if (reg_hit) begin
            prdata = arch_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ooo_core_pkg::idle;
        end else if (!psel) begin
            state <= ooo_core_pkg::idle;
        end else if (!penable) begin
            state <= ooo_core_pkg::setup;
        end else if (pready) begin
            state <= ooo_core_pkg::idle; // next transfer starts with its own setup
        end else begin
            state <= ooo_core_pkg::access;
        end
    end

endmodule

// File: hw/ooo_core_pkg.sv
package ooo_core_pkg;

    typedef logic [5:0] phys_tag_t; // tag 0 is hardwired zero
    typedef logic [4:0] arch_reg_t;
    typedef logic [2:0] rob_idx_t;

    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } apb_state_e;

endpackage

// File: hw/rv_isa_pkg.sv
package rv_isa_pkg;

    // only the integer alu major opcodes are accepted
    typedef enum logic [6:0] {
        op = 7'b0110011,
        op_imm = 7'b0010011,
        lui = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b // lui, result is the immediate
    } alu_op_e;

endpackage

// File: hw/ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

`define OOO_ARCH_REGS 32
`define OOO_PHYS_REGS 48
`define OOO_ROB_DEPTH 8
`define OOO_RS_DEPTH 4
`define OOO_XLEN 32

// apb register map
`define OOO_ADDR_INSTR 12'h000
`define OOO_ADDR_STATUS 12'h004
`define OOO_ADDR_REGS 12'h100 // one word per arch register

`endif
